// ==== design/sched_pkg.sv ====
`default_nettype none

package sched_pkg;

    localparam int word_w      = 32;
    localparam int cmd_words   = 6;
    localparam int num_units   = 4;
    localparam int num_threads = 16;
    localparam int unit_w      = $clog2(num_units);
    localparam int thread_w    = $clog2(num_threads);
    localparam int tag_w       = 16;
    localparam int done_w      = 20;

    localparam logic [3:0]  dimm_id    = 4'd0;
    localparam logic [31:0] dimm_base  = 32'h8000_0000;
    localparam logic [31:0] dimm_size  = 32'h2000_0000;
    localparam logic [31:0] dimm_end   = dimm_base + dimm_size; // first address past the window
    localparam logic [31:0] log_base   = 32'hC000_0000;
    localparam logic [31:0] log_stride = 32'h0400_0000;   // undo log area per thread

    localparam logic [7:0] op_log_reset = 8'd3;

    // lock entry states
    localparam logic [1:0] st_idle    = 2'b00;
    localparam logic [1:0] st_ready   = 2'b01;
    localparam logic [1:0] st_running = 2'b10;
    localparam logic [1:0] st_waiting = 2'b11;

    // w0 is the first word of the burst
    typedef struct packed {
        logic [word_w-1:0] w0;  // opcode 31:24, thread 15:8
        logic [word_w-1:0] w1;  // start address
        logic [word_w-1:0] w2;
        logic [word_w-1:0] w3;  // size in 31:16
        logic [word_w-1:0] w4;
        logic [word_w-1:0] w5;  // tag in 15:0
    } sched_cmd_t;

    typedef struct packed {
        logic                 valid;
        logic [1:0]           state;
        logic [num_units-1:0] dep;    // units this entry waits on
        logic [word_w-1:0]    start;
        logic [15:0]          size;
        logic [tag_w-1:0]     tag;
    } lock_entry_t;

    typedef struct packed {
        logic [unit_w-1:0] unit;
        logic [word_w-1:0] start;
        logic [15:0]       size;
        logic [tag_w-1:0]  tag;
    } lock_req_t;

endpackage

`default_nettype wire

// ==== design/sync_fifo.sv ====
`default_nettype none

module sync_fifo #(
    parameter int width = 32,
    parameter int depth = 16
) (
    input  wire              clk,
    input  wire              aresetn,
    input  wire              wr_en,
    input  wire [width-1:0]  din,
    input  wire              rd_en,
    output logic [width-1:0] dout,
    output logic             empty,
    output logic             full
);

    localparam int aw = $clog2(depth);

    logic [width-1:0] mem [depth];
    logic [aw-1:0]    wr_ptr;
    logic [aw-1:0]    rd_ptr;
    logic [aw:0]      count;
    logic             do_wr;
    logic             do_rd;

    assign empty = (count == 0);
    assign full  = (count == depth);
    assign do_wr = wr_en && !full;   // writes while full are dropped
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage and read port, one cycle latency
    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= din;
        if (do_rd) dout <= mem[rd_ptr];
    end

endmodule

`default_nettype wire

// ==== design/cmd_collector.sv ====
`default_nettype none

module cmd_collector (
    input  wire                              clk,
    input  wire                              aresetn,
    input  wire [sched_pkg::word_w-1:0]      command_in,
    input  wire                              command_valid,
    output sched_pkg::sched_cmd_t            cmd,
    output logic                             push,
    output logic                             receiving
);

    logic [2:0] cnt;   // slot of the next word

    assign receiving = command_valid || (cnt != 3'd0);

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            cnt  <= 3'd0;
            push <= 1'b0;
        end else begin
            push <= command_valid && (cnt == 3'd5);
            if (!command_valid)
                cnt <= 3'd0;        // broken burst is dropped
            else if (cnt == 3'd5)
                cnt <= 3'd0;
            else
                cnt <= cnt + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (command_valid) begin
            case (cnt)
                3'd0:    cmd.w0 <= command_in;
                3'd1:    cmd.w1 <= command_in;
                3'd2:    cmd.w2 <= command_in;
                3'd3:    cmd.w3 <= command_in;
                3'd4:    cmd.w4 <= command_in;
                default: cmd.w5 <= command_in;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/dispatch_fsm.sv ====
`default_nettype none

module dispatch_fsm (
    input  wire                                 clk,
    input  wire                                 aresetn,
    input  wire sched_pkg::sched_cmd_t          cmd,
    input  wire                                 q_empty,
    input  wire [sched_pkg::num_units-1:0]      free_units,
    output logic                                q_pop,
    output logic [sched_pkg::word_w-1:0]        command_broadcast,
    output logic [sched_pkg::num_units-1:0]     command_broadcast_valid,
    output logic [sched_pkg::word_w-1:0]        current_log_addr,
    output sched_pkg::lock_req_t                lock_req,
    output logic                                lock_write,
    output logic                                decoding
);

    typedef enum logic [2:0] {
        s_idle,
        s_pop_wait,
        s_decode,
        s_assign,
        s_broadcast,
        s_lock,
        s_done,
        s_log_reset
    } state_t;

    state_t                           state;
    logic [2:0]                       idx;       // broadcast word index
    logic [sched_pkg::unit_w-1:0]     unit;
    logic [sched_pkg::word_w-1:0]     log_ptr [sched_pkg::num_threads];
    logic [sched_pkg::thread_w-1:0]   thr;
    logic [sched_pkg::word_w-1:0]     clip_start;
    logic [sched_pkg::word_w-1:0]     cmd_end;
    logic [sched_pkg::word_w-1:0]     room;
    sched_pkg::sched_cmd_t            clipped;
    logic                             any_free;
    logic [sched_pkg::unit_w-1:0]     free_idx;

    assign thr = cmd.w0[8 +: sched_pkg::thread_w];

    // clip start and size to the module window
    always_comb begin
        clip_start = (cmd.w1 < sched_pkg::dimm_base) ? sched_pkg::dimm_base : cmd.w1;
        cmd_end    = cmd.w1 + {16'h0, cmd.w3[31:16]};
        room       = sched_pkg::dimm_end - clip_start;
        clipped    = cmd;
        clipped.w1 = clip_start;
        if (cmd_end >= sched_pkg::dimm_end)
            clipped.w3 = {room[15:0], 16'h0};
    end

    // lowest free unit wins
    always_comb begin
        any_free = 1'b0;
        free_idx = '0;
        for (int i = sched_pkg::num_units - 1; i >= 0; i--) begin
            if (free_units[i]) begin
                any_free = 1'b1;
                free_idx = i[sched_pkg::unit_w-1:0];
            end
        end
    end

    always_comb begin
        command_broadcast       = '0;
        command_broadcast_valid = '0;
        if (state == s_broadcast) begin
            command_broadcast = clipped[sched_pkg::word_w * (sched_pkg::cmd_words - 1 - idx)
                                        +: sched_pkg::word_w];
            command_broadcast_valid[unit] = 1'b1;
        end
    end

    assign q_pop      = (state == s_pop_wait);
    assign lock_write = (state == s_lock);
    assign decoding   = (state != s_idle);

    assign lock_req = '{unit:  unit,
                        start: cmd.w1,
                        size:  cmd.w3[31:16],
                        tag:   cmd.w5[15:0]};

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state            <= s_idle;
            idx              <= 3'd0;
            unit             <= '0;
            current_log_addr <= '0;
            for (int t = 0; t < sched_pkg::num_threads; t++)
                log_ptr[t] <= sched_pkg::log_base + 32'(t) * sched_pkg::log_stride;
        end else begin
            case (state)
                s_idle:     if (!q_empty) state <= s_pop_wait;
                s_pop_wait: state <= s_decode;     // queue head valid next cycle
                s_decode: begin
                    if (cmd.w0[31:24] == sched_pkg::op_log_reset)
                        state <= s_log_reset;
                    else
                        state <= s_assign;
                end
                s_assign: begin
                    if (any_free) begin            // otherwise wait here
                        unit             <= free_idx;
                        idx              <= 3'd0;
                        current_log_addr <= log_ptr[thr];
                        state            <= s_broadcast;
                    end
                end
                s_broadcast: begin
                    if (idx == 3'd5)
                        state <= s_lock;
                    else
                        idx <= idx + 3'd1;
                end
                s_lock: state <= s_done;
                s_done: begin
                    log_ptr[thr] <= current_log_addr + {16'h0, cmd.w3[31:16]};
                    state        <= s_idle;
                end
                s_log_reset: begin
                    log_ptr[thr] <= sched_pkg::log_base + 32'(thr) * sched_pkg::log_stride;
                    state        <= s_idle;
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/unit_tracker.sv ====
`default_nettype none

module unit_tracker (
    input  wire                                 clk,
    input  wire                                 aresetn,
    input  wire sched_pkg::lock_req_t           lock_req,
    input  wire                                 lock_write,
    input  wire [sched_pkg::num_units-1:0]      nearpmunit_done,
    input  wire                                 awvalid,
    input  wire [sched_pkg::word_w-1:0]         awaddr,
    input  wire                                 done_full,
    output logic [sched_pkg::num_units-1:0]     free_units,
    output logic [sched_pkg::num_units-1:0]     nearpm_go_ahead,
    output logic [sched_pkg::done_w-1:0]        done_word,
    output logic                                done_push,
    output logic                                write_hit
);

    localparam int nu = sched_pkg::num_units;

    sched_pkg::lock_entry_t          ent [nu];
    logic [nu-1:0]                   valid_mask;
    logic [nu-1:0]                   running;
    logic [nu-1:0]                   blocked;    // still waits on a live unit
    logic [nu-1:0]                   new_dep;
    logic [nu-1:0]                   pend;       // done seen, word not yet queued
    logic [nu-1:0]                   rel;
    logic [sched_pkg::unit_w-1:0]    rel_idx;
    logic [sched_pkg::word_w-1:0]    new_end;
    logic                            pending_go;
    logic [1:0]                      ga_state;

    always_comb begin
        new_end    = lock_req.start + 32'(lock_req.size);
        pending_go = 1'b0;
        write_hit  = 1'b0;
        for (int i = 0; i < nu; i++) begin
            valid_mask[i] = ent[i].valid;
            running[i]    = ent[i].valid && (ent[i].state == sched_pkg::st_running);
            pending_go    = pending_go || (ent[i].valid && !running[i]);
            new_dep[i]    = ent[i].valid && (ent[i].start < new_end) &&
                            (lock_req.start < ent[i].start + 32'(ent[i].size));
            write_hit     = write_hit || (awvalid && ent[i].valid && (awaddr >= ent[i].start) &&
                            (awaddr < ent[i].start + 32'(ent[i].size)));
        end
        for (int i = 0; i < nu; i++)
            blocked[i] = |(ent[i].dep & valid_mask);
    end

    // lowest pending unit is queued first
    always_comb begin
        rel_idx = '0;
        for (int i = nu - 1; i >= 0; i--)
            if (pend[i]) rel_idx = i[sched_pkg::unit_w-1:0];
        rel = '0;
        if (done_push) rel[rel_idx] = 1'b1;
    end

    assign free_units = ~valid_mask;
    assign done_push  = (|pend) && !done_full;
    assign done_word  = {sched_pkg::dimm_id, ent[rel_idx].tag};

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            for (int i = 0; i < nu; i++) begin
                ent[i].valid <= 1'b0;
                ent[i].state <= sched_pkg::st_idle;
                ent[i].dep   <= '0;
            end
            pend            <= '0;
            ga_state        <= 2'd0;
            nearpm_go_ahead <= '0;
        end else begin
            nearpm_go_ahead <= '0;

            if (lock_write) begin
                ent[lock_req.unit].valid <= 1'b1;
                ent[lock_req.unit].state <= (|new_dep) ? sched_pkg::st_waiting
                                                       : sched_pkg::st_ready;
                ent[lock_req.unit].dep   <= new_dep;
                ent[lock_req.unit].start <= lock_req.start;
                ent[lock_req.unit].size  <= lock_req.size;
                ent[lock_req.unit].tag   <= lock_req.tag;
            end

            case (ga_state)
                2'd0: if (pending_go) ga_state <= 2'd1;
                2'd1: begin                            // independent entries
                    for (int i = 0; i < nu; i++) begin
                        if (ent[i].valid && ent[i].state == sched_pkg::st_ready) begin
                            nearpm_go_ahead[i] <= 1'b1;
                            ent[i].state       <= sched_pkg::st_running;
                        end
                    end
                    ga_state <= 2'd2;
                end
                default: begin                         // waiting with no live blocker
                    for (int i = 0; i < nu; i++) begin
                        if (ent[i].valid && ent[i].state == sched_pkg::st_waiting && !blocked[i]) begin
                            nearpm_go_ahead[i] <= 1'b1;
                            ent[i].state       <= sched_pkg::st_running;
                        end
                    end
                    ga_state <= pending_go ? 2'd1 : 2'd0;
                end
            endcase

            // done pulses count only from running units
            pend <= (pend | (nearpmunit_done & running)) & ~rel;
            for (int i = 0; i < nu; i++) begin
                if (rel[i]) begin
                    ent[i].valid <= 1'b0;
                    ent[i].state <= sched_pkg::st_idle;
                end
                if (done_push) ent[i].dep[rel_idx] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/nearpm_scheduler.sv ====
`default_nettype none

module nearpm_scheduler (
    input  wire                                 clk,
    input  wire                                 aresetn,
    input  wire [31:0]                          command_in,
    input  wire                                 command_valid,
    input  wire [sched_pkg::num_units-1:0]      nearpmunit_done,
    input  wire                                 read_complete_split,
    input  wire                                 awvalid,
    input  wire [31:0]                          awaddr,
    output logic [31:0]                         command_broadcast,
    output logic [sched_pkg::num_units-1:0]     command_broadcast_valid,
    output logic [sched_pkg::num_units-1:0]     nearpm_go_ahead,
    output logic [31:0]                         current_log_addr,
    output logic [sched_pkg::done_w-1:0]        complete_split_out,
    output logic                                pending_complete_split_out,
    output logic                                stall_mem_channel
);

    sched_pkg::sched_cmd_t             col_cmd;
    sched_pkg::sched_cmd_t             q_cmd;
    sched_pkg::lock_req_t              lock_req;
    logic                              col_push;
    logic                              receiving;
    logic                              q_pop;
    logic                              q_empty;
    logic                              lock_write;
    logic                              decoding;
    logic                              write_hit;
    logic [sched_pkg::num_units-1:0]   free_units;
    logic [sched_pkg::done_w-1:0]      done_word;
    logic                              done_push;
    logic                              done_full;
    logic                              done_empty;

    cmd_collector u_collector (
        .clk(clk), .aresetn(aresetn),
        .command_in(command_in), .command_valid(command_valid),
        .cmd(col_cmd), .push(col_push), .receiving(receiving)
    );

    // in-order command queue
    sync_fifo #(.width($bits(sched_pkg::sched_cmd_t)), .depth(16)) cmd_queue (
        .clk(clk), .aresetn(aresetn),
        .wr_en(col_push), .din(col_cmd), .rd_en(q_pop),
        .dout(q_cmd), .empty(q_empty), .full()
    );

    dispatch_fsm u_dispatch (
        .clk(clk), .aresetn(aresetn),
        .cmd(q_cmd), .q_empty(q_empty), .free_units(free_units), .q_pop(q_pop),
        .command_broadcast(command_broadcast),
        .command_broadcast_valid(command_broadcast_valid),
        .current_log_addr(current_log_addr),
        .lock_req(lock_req), .lock_write(lock_write), .decoding(decoding)
    );

    unit_tracker u_tracker (
        .clk(clk), .aresetn(aresetn),
        .lock_req(lock_req), .lock_write(lock_write), .nearpmunit_done(nearpmunit_done),
        .awvalid(awvalid), .awaddr(awaddr), .done_full(done_full),
        .free_units(free_units), .nearpm_go_ahead(nearpm_go_ahead),
        .done_word(done_word), .done_push(done_push), .write_hit(write_hit)
    );

    sync_fifo #(.width(sched_pkg::done_w), .depth(32)) done_queue (
        .clk(clk), .aresetn(aresetn),
        .wr_en(done_push), .din(done_word), .rd_en(read_complete_split),
        .dout(complete_split_out), .empty(done_empty), .full(done_full)
    );

    assign pending_complete_split_out = !done_empty;

    // host holds off writes while commands are in flight or a write hits a lock
    assign stall_mem_channel = receiving || col_push || !q_empty || decoding || write_hit;

endmodule

`default_nettype wire

// ==== verif/tb_sched_model.svh ====
`ifndef TB_SCHED_MODEL_SVH
`define TB_SCHED_MODEL_SVH

int errors = 0;
logic [31:0] log_ptr_m [sched_pkg::num_threads];
sched_pkg::sched_cmd_t exp_cmds [$];     // raw commands in dispatch order
logic [31:0] exp_log [$];
logic [31:0] exp_done [$];
logic [31:0] act_start [sched_pkg::num_units];
logic [15:0] act_size [sched_pkg::num_units];
logic [15:0] act_tag [sched_pkg::num_units];
logic [sched_pkg::num_units-1:0] act_on = '0;
logic [sched_pkg::num_units-1:0] deps [sched_pkg::num_units];
int free_at [sched_pkg::num_units];      // first cycle the unit may be picked again

task automatic check(input string what, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
        errors++;
        $display("error at %0t: %s got %h expected %h", $time, what, act, exp);
    end
endtask

function automatic logic [31:0] thread_base(input int t);
    return sched_pkg::log_base + t * sched_pkg::log_stride;
endfunction

function automatic void model_reset();
    for (int t = 0; t < sched_pkg::num_threads; t++)
        log_ptr_m[t] = thread_base(t);
    for (int u = 0; u < sched_pkg::num_units; u++) begin
        deps[u] = '0;
        free_at[u] = 0;
    end
endfunction

// start raised to the window base, size cut at the window end
function automatic sched_pkg::sched_cmd_t clip_cmd(input sched_pkg::sched_cmd_t c);
    sched_pkg::sched_cmd_t r;
    logic [31:0] s;
    logic [31:0] e;
    logic [31:0] room;
    r = c;
    s = (c.w1 < sched_pkg::dimm_base) ? sched_pkg::dimm_base : c.w1;
    e = c.w1 + {16'h0, c.w3[31:16]};
    room = sched_pkg::dimm_base + sched_pkg::dimm_size - s;
    r.w1 = s;
    if (e >= sched_pkg::dimm_base + sched_pkg::dimm_size)
        r.w3 = {room[15:0], 16'h0};
    return r;
endfunction

function automatic void model_push(input sched_pkg::sched_cmd_t c);
    int t;
    t = c.w0[11:8];
    if (c.w0[31:24] == sched_pkg::op_log_reset) begin
        log_ptr_m[t] = thread_base(t);   // no broadcast for this one
    end else begin
        exp_cmds.push_back(c);
        exp_log.push_back(log_ptr_m[t]);
        log_ptr_m[t] = log_ptr_m[t] + {16'h0, c.w3[31:16]};
    end
endfunction

function automatic bit overlaps(input logic [31:0] s1, input logic [15:0] z1,
                                input logic [31:0] s2, input logic [15:0] z2);
    logic [31:0] e1;
    logic [31:0] e2;
    e1 = s1 + {16'h0, z1};
    e2 = s2 + {16'h0, z2};
    return (s1 < e2) && (s2 < e1);
endfunction

function automatic bit hits(input logic [31:0] a);
    bit h;
    h = 0;
    for (int u = 0; u < sched_pkg::num_units; u++)
        if (act_on[u] && a >= act_start[u] && a < act_start[u] + {16'h0, act_size[u]})
            h = 1;
    return h;
endfunction

function automatic int lowest_free(input int now);
    for (int u = 0; u < sched_pkg::num_units; u++)
        if (!act_on[u] && now >= free_at[u])
            return u;
    return -1;
endfunction

function automatic void start_unit(input int u, input sched_pkg::sched_cmd_t c);
    deps[u] = '0;
    for (int v = 0; v < sched_pkg::num_units; v++)
        if (act_on[v] && overlaps(act_start[v], act_size[v], c.w1, c.w3[31:16]))
            deps[u][v] = 1'b1;
    act_on[u] = 1'b1;
    act_start[u] = c.w1;                 // lock range uses the unclipped command
    act_size[u] = c.w3[31:16];
    act_tag[u] = c.w5[15:0];
    free_at[u] = 32'h7fff_ffff;
endfunction

function automatic void finish_unit(input int v, input int now);
    act_on[v] = 1'b0;
    free_at[v] = now + 3;                // entry drops two edges after the done is sampled
    for (int u = 0; u < sched_pkg::num_units; u++)
        deps[u][v] = 1'b0;
    exp_done.push_back({12'h0, sched_pkg::dimm_id, act_tag[v]});
endfunction

`endif

// ==== verif/tb_nearpm_scheduler.sv ====
`default_nettype none

module tb_nearpm_scheduler;

    localparam int n_cmds = 30;
    localparam int nu = sched_pkg::num_units;

    logic clk;
    logic aresetn;
    logic [31:0] command_in;
    logic command_valid;
    logic [nu-1:0] nearpmunit_done;
    logic read_complete_split;
    logic awvalid;
    logic [31:0] awaddr;
    logic [31:0] command_broadcast;
    logic [nu-1:0] command_broadcast_valid;
    logic [nu-1:0] nearpm_go_ahead;
    logic [31:0] current_log_addr;
    logic [sched_pkg::done_w-1:0] complete_split_out;
    logic pending_complete_split_out;
    logic stall_mem_channel;

    integer seed = 32'h6992_1181;
    int cyc = 0;
    int ga_total = 0;
    int tests = 0;
    int failed = 0;
    int err_mark = 0;
    int bidx = 0;
    int bunit;
    int base_ga;
    logic [nu-1:0] hold = '0;        // emulated units hold their done while set
    logic [nu-1:0] ga_seen = '0;
    logic pop_check = 1'b0;
    logic [15:0] next_tag = 16'h0100;
    sched_pkg::sched_cmd_t bclip;

    `include "tb_sched_model.svh"

    nearpm_scheduler uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(40 * (n_cmds * 200 + 500));
        $display("timeout: the run did not finish in the allowed time");
        $display("Test failures found");
        $finish;
    end

    // host side of the completion queue, one pop every other cycle
    always @(posedge clk) begin
        #2;
        read_complete_split = aresetn && pending_complete_split_out && !read_complete_split;
    end

    always @(negedge clk) begin
        if (aresetn) begin
            cyc++;
            if (pop_check) begin
                if (exp_done.size() == 0) begin
                    errors++;
                    $display("a completion word was popped with none expected");
                end else begin
                    check("completion word", complete_split_out, exp_done.pop_front());
                end
            end
            pop_check = read_complete_split;
            for (int u = 0; u < nu; u++) begin
                if (nearpm_go_ahead[u]) begin
                    check("blockers left at go-ahead", deps[u], 0);
                    ga_seen[u] = 1'b1;
                    ga_total++;
                end
            end
            for (int u = 0; u < nu; u++)
                if (nearpmunit_done[u]) finish_unit(u, cyc);
            if (command_broadcast_valid != 0) begin
                if (bidx == 0) begin
                    if (exp_cmds.size() == 0) begin
                        errors++;
                        $display("a broadcast started with no command queued");
                    end else begin
                        bclip = clip_cmd(exp_cmds[0]);
                        bunit = lowest_free(cyc);
                        if (bunit < 0) begin
                            errors++;
                            $display("a broadcast started while every unit was busy");
                        end else begin
                            check("broadcast unit", command_broadcast_valid, 1 << bunit);
                            check("log address", current_log_addr, exp_log[0]);
                            start_unit(bunit, exp_cmds[0]);
                        end
                        void'(exp_cmds.pop_front());
                        void'(exp_log.pop_front());
                    end
                end else if (bunit >= 0) begin
                    check("broadcast unit held", command_broadcast_valid, 1 << bunit);
                end
                check("broadcast word", command_broadcast, word_of(bclip, bidx));
                bidx = (bidx == 5) ? 0 : bidx + 1;
            end else begin
                check("broadcast bus outside window", command_broadcast, 0);
            end
        end
    end

    function automatic logic [31:0] word_of(input sched_pkg::sched_cmd_t c, input int i);
        case (i)
            0: return c.w0;
            1: return c.w1;
            2: return c.w2;
            3: return c.w3;
            4: return c.w4;
            default: return c.w5;
        endcase
    endfunction

    function automatic sched_pkg::sched_cmd_t make_cmd(input logic [7:0] op, input int thr,
                                                       input logic [31:0] start,
                                                       input logic [15:0] size);
        sched_pkg::sched_cmd_t c;
        c.w0 = {op, 8'h00, 4'h0, 4'(thr), 8'h00};
        c.w1 = start;
        c.w2 = $random(seed);
        c.w3 = {size, 16'h0};
        c.w4 = $random(seed);
        c.w5 = {16'h0, next_tag};
        next_tag++;
        return c;
    endfunction

    // starts cluster at the window edges so overlap and clipping both show up
    function automatic sched_pkg::sched_cmd_t rand_cmd();
        logic [31:0] r;
        logic [31:0] start;
        r = $random(seed);
        case (r[1:0])
            2'd0, 2'd1: start = sched_pkg::dimm_base + {20'h0, r[13:2]} - 32'h400;
            2'd2: start = sched_pkg::dimm_base + sched_pkg::dimm_size - {20'h0, r[15:4]};
            default: start = sched_pkg::dimm_base + {8'h0, r[27:16], 12'h0};
        endcase
        return make_cmd(8'h10, r[31:28], start, 16'h10 + {5'h0, r[26:16]});
    endfunction

    task automatic send_cmd(input sched_pkg::sched_cmd_t c);
        do begin
            @(posedge clk);
            #2;
        end while (stall_mem_channel);
        model_push(c);
        for (int i = 0; i < 6; i++) begin
            command_valid = 1'b1;
            command_in = word_of(c, i);
            @(negedge clk);
            check("stall while receiving", stall_mem_channel, 1);
            @(posedge clk);
            #2;
        end
        command_valid = 1'b0;
        command_in = '0;
    endtask

    task automatic run_unit(input int u);
        int delay;
        forever begin
            @(posedge clk);
            if (ga_seen[u]) begin
                ga_seen[u] = 1'b0;
                delay = 1 + ({$random(seed)} % 12);
                repeat (delay) @(posedge clk);
                while (hold[u]) @(posedge clk);
                #2 nearpmunit_done[u] = 1'b1;
                @(posedge clk);
                #2 nearpmunit_done[u] = 1'b0;
            end
        end
    endtask

    task automatic wait_idle();
        do @(negedge clk);
        while (exp_cmds.size() != 0 || act_on != 0 || exp_done.size() != 0 || pop_check ||
               stall_mem_channel);
        repeat (3) @(negedge clk);
    endtask

    task automatic wait_go(input int n);
        while (ga_total < n) @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors != err_mark) begin
            failed++;
            $display("%s: FAIL", name);
        end else begin
            $display("%s: ok", name);
        end
        err_mark = errors;
    endtask

    task automatic write_probe(input logic [31:0] a);
        @(posedge clk);
        #2 awvalid = 1'b1;
        awaddr = a;
        @(negedge clk);
        check("stall on host write", stall_mem_channel, hits(a));
    endtask

    initial begin
        aresetn = 1'b0;
        command_in = '0;
        command_valid = 1'b0;
        nearpmunit_done = '0;
        read_complete_split = 1'b0;
        awvalid = 1'b0;
        awaddr = '0;
        model_reset();
        repeat (4) @(posedge clk);
        #2 aresetn = 1'b1;
        fork
            run_unit(0);
            run_unit(1);
            run_unit(2);
            run_unit(3);
        join_none

        repeat (10) send_cmd(rand_cmd());
        wait_idle();
        finish_test("random dispatch");

        send_cmd(make_cmd(8'h10, 5, sched_pkg::dimm_base + 32'h1000, 16'h40));
        send_cmd(make_cmd(8'h10, 5, sched_pkg::dimm_base + 32'h1100, 16'h80));
        send_cmd(make_cmd(sched_pkg::op_log_reset, 5, 32'h0, 16'h0));
        send_cmd(make_cmd(8'h10, 5, sched_pkg::dimm_base + 32'h1200, 16'h20));
        wait_idle();
        finish_test("log pointers");

        hold = '1;
        base_ga = ga_total;
        send_cmd(make_cmd(8'h10, 1, sched_pkg::dimm_base + 32'h2000, 16'h100));
        send_cmd(make_cmd(8'h10, 2, sched_pkg::dimm_base + 32'h2080, 16'h100)); // overlaps
        send_cmd(make_cmd(8'h10, 3, sched_pkg::dimm_base + 32'h3000, 16'h10));
        repeat (30) @(negedge clk);
        check("go-aheads with one blocked command", ga_total - base_ga, 2);
        hold = '0;
        wait_idle();
        check("go-aheads after release", ga_total - base_ga, 3);
        finish_test("dependence");

        hold = '1;
        base_ga = ga_total;
        send_cmd(make_cmd(8'h10, 4, sched_pkg::dimm_base + 32'h4000, 16'h20));
        send_cmd(make_cmd(8'h10, 4, sched_pkg::dimm_base + 32'h4100, 16'h20));
        send_cmd(make_cmd(8'h10, 6, sched_pkg::dimm_base + 32'h4200, 16'h20));
        wait_go(base_ga + 3);
        repeat (20) @(negedge clk);
        hold = '0;                       // all three finish in one cycle
        wait_idle();
        finish_test("completion order");

        hold = '1;
        send_cmd(make_cmd(8'h10, 7, sched_pkg::dimm_base + 32'h5000, 16'h100));
        send_cmd(make_cmd(8'h10, 8, sched_pkg::dimm_base + 32'h7000, 16'h40));
        repeat (30) @(negedge clk);
        check("stall when idle", stall_mem_channel, 0);
        write_probe(sched_pkg::dimm_base + 32'h5010);
        write_probe(sched_pkg::dimm_base + 32'h50ff);
        write_probe(sched_pkg::dimm_base + 32'h5100);
        write_probe(sched_pkg::dimm_base + 32'h7020);
        write_probe(sched_pkg::dimm_base + 32'h6000);
        write_probe(sched_pkg::dimm_base + {16'h0, 16'($random(seed))});
        @(posedge clk);
        #2 awvalid = 1'b0;
        awaddr = sched_pkg::dimm_base + 32'h5010;
        @(negedge clk);
        check("stall without awvalid", stall_mem_channel, 0);
        hold = '0;
        wait_idle();
        finish_test("stall and write hits");

        hold = '1;
        base_ga = ga_total;
        for (int i = 0; i < 4; i++)
            send_cmd(make_cmd(8'h10, 9, sched_pkg::dimm_base + 32'h8000 + i * 32'h100, 16'h40));
        wait_go(base_ga + 4);
        send_cmd(make_cmd(8'h10, 10, sched_pkg::dimm_base + 32'h9000, 16'h40));
        repeat (20) @(negedge clk);
        check("fifth command still queued", exp_cmds.size(), 1);
        hold[2] = 1'b0;                  // free unit 2 only
        while (exp_cmds.size() != 0) @(negedge clk);
        hold = '0;
        wait_idle();
        finish_test("saturation");

        $display("tests run %0d, tests failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verif
design/sched_pkg.sv
design/sync_fifo.sv
design/cmd_collector.sv
design/dispatch_fsm.sv
design/unit_tracker.sv
design/nearpm_scheduler.sv
verif/tb_nearpm_scheduler.sv

// ==== Bender.yml ====
package:
  name: nearpm_scheduler

sources:
  - design/sched_pkg.sv
  - design/sync_fifo.sv
  - design/cmd_collector.sv
  - design/dispatch_fsm.sv
  - design/unit_tracker.sv
  - design/nearpm_scheduler.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_nearpm_scheduler.sv
